// ==== flist.f ====
logic/rv32i_types.sv
logic/free_list.sv
logic/rename_map.sv
logic/rob.sv
logic/rename_top.sv
verification/rob_properties.sv
verification/rename_tb.sv

// ==== logic/free_list.sv ====
`timescale 1ns/1ps

module free_list
import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // allocation side
    input  logic      pop,
    output phys_reg_t free_phys,
    output logic      empty,

    // release side, fed by commit
    input  logic      push,
    input  phys_reg_t push_phys
);

    phys_reg_t slots [FREE_REGS];

    logic [FL_IDX_W:0] head;            // msb is the wrap bit
    logic [FL_IDX_W:0] tail;            // msb is the wrap bit

    logic [FL_IDX_W-1:0] head_idx;
    logic [FL_IDX_W-1:0] tail_idx;

    assign head_idx = head[FL_IDX_W-1:0];
    assign tail_idx = tail[FL_IDX_W-1:0];

    // equal pointers, same lap
    assign empty = (head == tail);

    assign free_phys = slots[head_idx];  // next reg to hand out

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= {1'b1, {FL_IDX_W{1'b0}}};   // one full lap ahead
            for (int i = 0; i < FREE_REGS; i++) begin
                slots[i] <= phys_reg_t'(ARCH_REGS + i);   // 32 .. 63
            end
        end else begin
            if (push) begin
                slots[tail_idx] <= push_phys;
                tail <= tail + 1'b1;
            end
            // pop only advances, the slot is simply reused later
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule : free_list

// ==== logic/rename_map.sv ====
`timescale 1ns/1ps

module rename_map
import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction source
    input  logic      dispatch,
    input  arch_reg_t arch_dest,

    // resource status
    input  phys_reg_t free_phys,
    input  logic      free_empty,
    input  logic      rob_full,
    input  rob_idx_t  tail_idx,

    output logic      dispatch_ready,
    output logic      alloc_fire,
    output alloc_t    alloc
);

    phys_reg_t rat [ARCH_REGS];         // speculative alias table

    // needs a free reg and a rob slot
    assign dispatch_ready = !free_empty && !rob_full;
    assign alloc_fire     = dispatch && dispatch_ready;

    always_comb begin
        alloc.rob_idx   = tail_idx;
        alloc.arch      = arch_dest;
        alloc.phys      = free_phys;
        alloc.prev_phys = rat[arch_dest];   // mapping before this instruction
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= phys_reg_t'(i);   // identity map
            end
        end else if (alloc_fire) begin
            rat[arch_dest] <= free_phys;
        end
    end

endmodule : rename_map

// ==== logic/rename_top.sv ====
`timescale 1ns/1ps

module rename_top
import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,

    // front end
    input  logic      dispatch,
    input  arch_reg_t arch_dest,
    output logic      dispatch_ready,
    output alloc_t    alloc,

    // completion
    input  logic      cdb_valid,
    input  rob_idx_t  cdb_rob_idx,

    // retire
    output commit_t   commit
);

    phys_reg_t free_phys;
    logic      free_empty;
    logic      rob_full;
    rob_idx_t  tail_idx;
    logic      alloc_fire;

    free_list u_free_list (
        .clk       (clk),
        .rst       (rst),
        .pop       (alloc_fire),
        .free_phys (free_phys),
        .empty     (free_empty),
        .push      (commit.valid),      // retired reg released
        .push_phys (commit.freed)
    );

    rename_map u_rename_map (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .arch_dest      (arch_dest),
        .free_phys      (free_phys),
        .free_empty     (free_empty),
        .rob_full       (rob_full),
        .tail_idx       (tail_idx),
        .dispatch_ready (dispatch_ready),
        .alloc_fire     (alloc_fire),
        .alloc          (alloc)
    );

    rob u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc_fire  (alloc_fire),
        .alloc       (alloc),
        .tail_idx    (tail_idx),
        .full        (rob_full),
        .cdb_valid   (cdb_valid),
        .cdb_rob_idx (cdb_rob_idx),
        .commit      (commit)
    );

endmodule : rename_top

// ==== logic/rob.sv ====
`timescale 1ns/1ps

module rob
import rv32i_types::*;
(
    input  logic     clk,
    input  logic     rst,

    // dispatch side
    input  logic     alloc_fire,
    input  alloc_t   alloc,
    output rob_idx_t tail_idx,
    output logic     full,

    // completion broadcast
    input  logic     cdb_valid,
    input  rob_idx_t cdb_rob_idx,

    // retire side
    output commit_t  commit
);

    rob_entry_t entries [ROB_DEPTH];

    logic [ROB_IDX_W:0] head;           // extra wrap bit
    logic [ROB_IDX_W:0] tail;           // extra wrap bit

    rob_idx_t   head_idx;
    rob_entry_t head_entry;
    rob_entry_t new_entry;

    logic empty;
    logic commit_fire;

    assign head_idx = head[ROB_IDX_W-1:0];
    assign tail_idx = tail[ROB_IDX_W-1:0];

    // same slot, different lap
    assign full  = (head_idx == tail_idx) && (head[ROB_IDX_W] != tail[ROB_IDX_W]);
    assign empty = (head == tail);

    assign head_entry = entries[head_idx];

    // oldest instruction retires once its result is in
    assign commit_fire = !empty && head_entry.done;

    always_comb begin
        new_entry.done      = 1'b0;     // waits for its cdb broadcast
        new_entry.arch      = alloc.arch;
        new_entry.phys      = alloc.phys;
        new_entry.prev_phys = alloc.prev_phys;
    end

    always_comb begin
        commit.valid = commit_fire;
        commit.arch  = head_entry.arch;
        commit.phys  = head_entry.phys;
        commit.freed = head_entry.prev_phys;   // old mapping is now dead
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].done <= 1'b0;
            end
        end else begin
            // completion first so a fresh allocation below overrides it
            if (cdb_valid) begin
                entries[cdb_rob_idx].done <= 1'b1;
            end

            if (commit_fire) begin
                entries[head_idx].done <= 1'b0;   // slot free again
                head <= head + 1'b1;
            end

            // a stale broadcast to this slot is dropped here
            if (alloc_fire) begin
                entries[tail_idx] <= new_entry;
                tail <= tail + 1'b1;
            end
        end
    end

endmodule : rob

// ==== logic/rv32i_types.sv ====
package rv32i_types;

    // machine sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 32;

    // derived sizes
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;   // regs not mapped at reset
    localparam int FL_IDX_W  = $clog2(FREE_REGS);
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [ROB_IDX_W-1:0]         rob_idx_t;

    // one reorder buffer slot
    typedef struct packed {
        logic      done;                // result broadcast on cdb
        arch_reg_t arch;
        phys_reg_t phys;                // newly allocated mapping
        phys_reg_t prev_phys;           // mapping replaced at dispatch
    } rob_entry_t;

    // result of renaming one instruction
    typedef struct packed {
        rob_idx_t  rob_idx;
        arch_reg_t arch;
        phys_reg_t phys;
        phys_reg_t prev_phys;
    } alloc_t;

    // retire record, freed reg goes back to the free list
    typedef struct packed {
        logic      valid;               // one pulse per retired instruction
        arch_reg_t arch;
        phys_reg_t phys;
        phys_reg_t freed;
    } commit_t;

endpackage : rv32i_types

// ==== run.sh ====
#!/bin/sh
# build and run the rename testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module rename_tb -o rename_sim

./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb
    import rv32i_types::*;
();

    localparam int COMMIT_TIMEOUT = 200;   // cycles allowed per commit wait
    localparam int NUM_TESTS      = 6;

    typedef enum int {ORD_IN, ORD_REV, ORD_SHUF} order_t;

    typedef struct {
        string  name;
        int     count;                  // dispatches
        int     base;                   // first arch reg
        int     stride;                 // arch step, 0 renames one reg
        order_t order;                  // completion order
        bit     probe;                  // stall against a full rob
        int     idle;
    } test_row_t;

    logic      clk         = 1'b0;
    logic      rst         = 1'b1;
    logic      dispatch    = 1'b0;
    arch_reg_t arch_dest   = '0;
    logic      cdb_valid   = 1'b0;
    rob_idx_t  cdb_rob_idx = '0;
    logic      dispatch_ready;
    alloc_t    alloc;
    commit_t   commit;

    test_row_t tests [NUM_TESTS];

    phys_reg_t model_rat [ARCH_REGS];   // reference alias table
    phys_reg_t model_free [$];          // reference free fifo
    alloc_t    outstanding [$];         // dispatched, not yet retired
    rob_idx_t  model_tail;
    rob_idx_t  seq_rob [ROB_DEPTH + 1];
    int        order_list [ROB_DEPTH + 1];

    string     cur_name     = "reset";
    int        commits_seen = 0;
    int        errors       = 0;
    int        test_errors  = 0;
    int        passed       = 0;
    int        failed       = 0;
    bit        timed_out    = 1'b0;
    bit        have_last    = 1'b0;
    arch_reg_t last_arch;
    phys_reg_t last_phys;

    rename_top UUT (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .arch_dest      (arch_dest),
        .dispatch_ready (dispatch_ready),
        .alloc          (alloc),
        .cdb_valid      (cdb_valid),
        .cdb_rob_idx    (cdb_rob_idx),
        .commit         (commit)
    );

    always #5 clk = ~clk;

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("error %s: %s expected %0d actual %0d", cur_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic tick();              // to the next drive point
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch_one(input arch_reg_t arch);
        alloc_t exp;
        dispatch  = 1'b1;
        arch_dest = arch;
        #1;
        exp.rob_idx   = model_tail;
        exp.arch      = arch;
        exp.phys      = model_free[0];
        exp.prev_phys = model_rat[arch];
        check_value("dispatch_ready", 1, dispatch_ready);
        check_value("alloc rob_idx", exp.rob_idx, alloc.rob_idx);
        check_value("alloc arch", exp.arch, alloc.arch);
        check_value("alloc phys", exp.phys, alloc.phys);
        check_value("alloc prev_phys", exp.prev_phys, alloc.prev_phys);
        if (have_last && last_arch == arch) begin
            check_value("chained prev_phys", last_phys, alloc.prev_phys);
        end
        void'(model_free.pop_front());
        model_rat[arch] = exp.phys;
        outstanding.push_back(exp);
        model_tail++;
        have_last = 1'b1;
        last_arch = arch;
        last_phys = exp.phys;
        @(posedge clk);
        #1;
        dispatch = 1'b0;
    endtask

    task automatic probe_blocked();     // rob and free list both exhausted
        check_value("dispatch_ready when full", 0, dispatch_ready);
        dispatch  = 1'b1;
        arch_dest = 5'd17;
        repeat (3) begin
            #1;
            check_value("dispatch_ready when full", 0, dispatch_ready);
            @(posedge clk);
            #1;
        end
        dispatch = 1'b0;
    endtask

    task automatic complete_one(input rob_idx_t idx);
        cdb_valid   = 1'b1;
        cdb_rob_idx = idx;
        tick();
        cdb_valid   = 1'b0;
    endtask

    task automatic wait_commits(input int target);
        int cycles;
        cycles = 0;
        while (commits_seen < target && cycles < COMMIT_TIMEOUT) begin
            tick();
            cycles++;
        end
        if (commits_seen < target) begin
            $display("%s: no commit %0d within %0d cycles", cur_name, target, cycles);
            timed_out = 1'b1;
            note_error();
        end
    endtask

    task automatic build_order(input int first, input int cnt, input order_t mode);
        int j;
        int tmp;
        for (int i = 0; i < cnt; i++) begin
            order_list[i] = (mode == ORD_REV) ? first + cnt - 1 - i : first + i;
        end
        if (mode == ORD_SHUF) begin
            for (int i = cnt - 1; i > 0; i--) begin
                j             = $urandom % (i + 1);
                tmp           = order_list[i];
                order_list[i] = order_list[j];
                order_list[j] = tmp;
            end
        end
    endtask

    task automatic run_test(input int t);
        int base_commits;
        int total;
        int first;
        cur_name     = tests[t].name;
        test_errors  = 0;
        base_commits = commits_seen;
        for (int k = 0; k < tests[t].count; k++) begin
            seq_rob[k] = model_tail;
            dispatch_one(arch_reg_t'((tests[t].base + k * tests[t].stride) % ARCH_REGS));
        end
        total = tests[t].count;
        first = 0;
        if (tests[t].probe) begin
            probe_blocked();
            complete_one(seq_rob[0]);
            wait_commits(base_commits + 1);
            seq_rob[total] = model_tail;    // one freed slot taken again
            dispatch_one(arch_reg_t'(tests[t].base));
            total++;
            first = 1;
        end
        build_order(first, total - first, tests[t].order);
        for (int i = 0; i < total - first; i++) begin
            complete_one(seq_rob[order_list[i]]);
        end
        wait_commits(base_commits + total);
        repeat (tests[t].idle) tick();
    endtask

    // retire checker, commit is stable at the falling edge
    always @(negedge clk) begin : commit_monitor
        alloc_t exp;
        if (!rst && commit.valid) begin
            assert (outstanding.size() > 0) else begin
                $display("%s: commit pulse with no instruction outstanding", cur_name);
                note_error();
            end
            if (outstanding.size() > 0) begin
                exp = outstanding.pop_front();
                check_value("commit arch", exp.arch, commit.arch);
                check_value("commit phys", exp.phys, commit.phys);
                check_value("commit freed", exp.prev_phys, commit.freed);
                model_free.push_back(exp.prev_phys);
            end
            commits_seen++;
        end
    end

    initial begin
        void'($urandom(32'ha9a4_5345));
        tests[0] = '{"first_fill",      32, 0,  1, ORD_IN,   1'b0, 3};
        tests[1] = '{"reverse_done",    12, 5,  3, ORD_REV,  1'b0, 2};
        tests[2] = '{"shuffled_done",   20, 1,  7, ORD_SHUF, 1'b0, 2};
        tests[3] = '{"same_dest_chain", 8,  9,  0, ORD_SHUF, 1'b0, 1};
        tests[4] = '{"rob_full_stall",  32, 3,  5, ORD_IN,   1'b1, 2};
        tests[5] = '{"refill_reuse",    24, 31, 1, ORD_REV,  1'b0, 2};
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_rat[i] = phys_reg_t'(i);              // identity at reset
        end
        for (int i = 0; i < PHYS_REGS - ARCH_REGS; i++) begin
            model_free.push_back(phys_reg_t'(ARCH_REGS + i));
        end
        model_tail = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("dispatch_ready after reset", 1, dispatch_ready);
        check_value("commit valid after reset", 0, commit.valid);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (!timed_out) begin
                run_test(t);
                $display("test %s: %s", cur_name, test_errors == 0 ? "ok" : "failed");
                if (test_errors == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
            end
        end
        $display("tests passed %0d failed %0d, commits %0d, errors %0d",
                 passed, failed, commits_seen, errors);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : rename_tb

bind rob rob_properties u_rob_props (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit.valid),
    .head_idx     (head_idx),
    .tail_idx     (tail_idx),
    .cdb_valid    (cdb_valid),
    .cdb_rob_idx  (cdb_rob_idx),
    .full         (full),
    .alloc_fire   (alloc_fire)
);

// ==== verification/rob_properties.sv ====
`timescale 1ns/1ps

module rob_properties
import rv32i_types::*;
(
    input logic     clk,
    input logic     rst,
    input logic     commit_valid,
    input rob_idx_t head_idx,
    input rob_idx_t tail_idx,
    input logic     cdb_valid,
    input rob_idx_t cdb_rob_idx,
    input logic     full,
    input logic     alloc_fire
);

    logic [ROB_DEPTH-1:0] completed;    // cdb seen since the slot was written
    logic [ROB_IDX_W:0]   occupancy;    // allocations minus commits

    always_ff @(posedge clk) begin
        if (rst) begin
            completed <= '0;
            occupancy <= '0;
        end else begin
            if (cdb_valid) begin
                completed[cdb_rob_idx] <= 1'b1;
            end
            if (alloc_fire) begin
                completed[tail_idx] <= 1'b0;    // fresh entry starts unfinished
            end
            case ({alloc_fire, commit_valid})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // only a completed head may retire
    commit_needs_done: assert property (
        @(posedge clk) disable iff (rst)
        commit_valid |-> (occupancy != 0) && completed[head_idx]
    ) else $error("commit pulse while the head entry has not completed");

    // status outputs stay known
    status_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown({full, commit_valid})
    ) else $error("rob full or commit valid is unknown");

    // rename gating keeps writes out of a full rob
    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst)
        (occupancy == ROB_DEPTH) |-> !alloc_fire
    ) else $error("allocation while the rob is full");

endmodule : rob_properties
